// ==== hdl/erx_pkg.sv ====
// Packet layout follows the 104-bit mesh format; rx_id must match the receiver's own 12-bit address region
package erx_pkg;

   // ####################
   // Sizes
   // ####################
   localparam int pw = 104;                     // Packet width
   localparam int aw = 32;                      // Address width
   localparam int dw = 32;                      // Data width

   // Upper address bits of the receiver register region
   localparam logic [11:0] rx_id = 12'h810;

   // Address step between stream beats
   localparam logic [aw-1:0] stream_incr = aw'(8);

   // ####################
   // Packet field positions
   // ####################
   localparam int pkt_access_bit   = 0;
   localparam int pkt_write_bit    = 1;
   localparam int pkt_datamode_lsb = 2;
   localparam int pkt_datamode_msb = 3;
   localparam int pkt_ctrlmode_lsb = 4;
   localparam int pkt_ctrlmode_msb = 7;
   localparam int pkt_dstaddr_lsb  = 8;
   localparam int pkt_dstaddr_msb  = 39;
   localparam int pkt_data_lsb     = 40;
   localparam int pkt_data_msb     = 71;
   localparam int pkt_srcaddr_lsb  = 72;
   localparam int pkt_srcaddr_msb  = 103;

   // ####################
   // Enums
   // ####################

   // Byte lane of the frame rise, align_7 is byte 0 of the group
   typedef enum logic [2:0] {
      align_0,
      align_1,
      align_2,
      align_3,
      align_4,
      align_5,
      align_6,
      align_7
   } align_e;

   // Transfer size
   typedef enum logic [1:0] {
      dm_byte,
      dm_half,
      dm_word,
      dm_double
   } datamode_e;

endpackage

// ==== hdl/erx_frame_align.sv ====
// Only the earliest frame rise in a group is decoded; a second rise inside the same group is ignored
`timescale 1ns/1ps

module erx_frame_align
   import erx_pkg::*;
(
   input  logic        reset,
   input  logic        rx_lclk_div4,
   input  logic [7:0]  rx_frame_par,
   input  logic [63:0] rx_data_par,
   output logic [63:0] rx_data_in,
   output align_e      rx_align,
   output logic        rx_active,
   output logic [7:0]  frame_prev_par
);

   logic [7:0] prev_lane;                       // Frame bit one byte earlier in time
   logic [7:0] rise_vec;
   logic       edge_found;
   align_e     edge_lane;

   // Lane 7 looks back into the last byte of the previous group
   assign prev_lane = {frame_prev_par[0], rx_frame_par[7:1]};
   assign rise_vec  = rx_frame_par & ~prev_lane;

   // Scan upward so the highest lane wins
   always_comb
   begin
      edge_found = 1'b0;
      edge_lane  = align_0;
      for (int i = 0; i < 8; i++)
      begin
         if (rise_vec[i])
         begin
            edge_found = 1'b1;
            edge_lane  = align_e'(3'(i));
         end
      end
   end

   always_ff @(posedge rx_lclk_div4 or posedge reset)
   begin
      if (reset)
      begin
         rx_align       <= align_0;
         rx_active      <= 1'b0;
         frame_prev_par <= '0;
      end
      else
      begin
         frame_prev_par <= rx_frame_par;
         rx_active      <= edge_found;     // One group only
         if (edge_found)
            rx_align <= edge_lane;         // Held for stream beats
      end
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      rx_data_in <= rx_data_par;
   end

   a_align_known : assert property (@(posedge rx_lclk_div4) disable iff (reset)
      rx_active |-> !$isunknown(rx_align));

endmodule

// ==== hdl/erx_field_decode.sv ====
// Alignment is held between frame rises so that stream beats reuse the byte positions of their transaction
`timescale 1ns/1ps

module erx_field_decode
   import erx_pkg::*;
(
   input  logic          reset,
   input  logic          rx_lclk_div4,
   input  logic [63:0]   rx_data_in,
   input  align_e        rx_align,
   input  logic          rx_active,
   output logic [3:0]    ctrlmode,
   output logic [aw-1:0] dstaddr_dec,
   output datamode_e     datamode,
   output logic          write,
   output logic          access_dec,
   output logic [dw-1:0] data,
   output logic [aw-1:0] srcaddr
);

   // Transaction bytes 1 to 13, header byte 0 is dropped
   logic [13:1][7:0] txn_1;
   logic [13:1][7:0] txn_2;
   logic [13:1][7:0] fill_1;
   logic [13:1][7:0] fill_2;
   logic [13:1][7:0] fill_3;

   align_e align_1;
   align_e align_2;
   logic   active_1;
   logic   active_2;

   // Drops the bytes of one group into their transaction slots
   // first is the transaction index of the byte on lane 7
   function automatic logic [13:1][7:0] place_bytes(
      input logic [13:1][7:0] cur,
      input logic [63:0]      grp,
      input int               first
   );
      logic [13:1][7:0] res;
      int               k;
      res = cur;
      for (int p = 0; p < 8; p++)
      begin
         k = first + p;
         if (k >= 1 && k <= 13)
            res[k] = grp[63 - 8*p -: 8];
      end
      return res;
   endfunction

   // ####################
   // Stage 1
   // ####################

   // Header sits on lane rx_align of the first group
   assign fill_1 = place_bytes('0, rx_data_in, int'(rx_align) - 7);

   // ####################
   // Stage 2
   // ####################
   assign fill_2 = place_bytes(txn_1, rx_data_in, int'(align_1) + 1);

   // Address bytes are complete here, one stage ahead of the rest
   assign dstaddr_dec = {txn_2[1][3:0], txn_2[2], txn_2[3], txn_2[4], txn_2[5][7:4]};

   // ####################
   // Stage 3
   // ####################

   // Only the tail of data and srcaddr can land in the third group
   assign fill_3 = place_bytes(txn_2, rx_data_in, int'(align_2) + 9);

   always_ff @(posedge rx_lclk_div4 or posedge reset)
   begin
      if (reset)
      begin
         align_1    <= align_0;
         align_2    <= align_0;
         active_1   <= 1'b0;
         active_2   <= 1'b0;
         access_dec <= 1'b0;
      end
      else
      begin
         align_1    <= rx_align;
         align_2    <= align_1;
         active_1   <= rx_active;
         active_2   <= active_1;
         access_dec <= fill_3[5][0] & active_2;   // Fresh transactions only
      end
   end

   // Byte buffers and decoded fields
   always_ff @(posedge rx_lclk_div4)
   begin
      txn_1    <= fill_1;
      txn_2    <= fill_2;
      ctrlmode <= fill_3[1][7:4];
      datamode <= datamode_e'(fill_3[5][3:2]);
      write    <= fill_3[5][1];
      data     <= {fill_3[6], fill_3[7], fill_3[8], fill_3[9]};
      srcaddr  <= {fill_3[10], fill_3[11], fill_3[12], fill_3[13]};
   end

endmodule

// ==== hdl/erx_stream_track.sv ====
// A stream continues while the frame is high on the first byte of each next beat; other lanes are not checked
`timescale 1ns/1ps

module erx_stream_track
   import erx_pkg::*;
(
   input  logic          reset,
   input  logic          rx_lclk_div4,
   input  align_e        rx_align,
   input  logic          rx_active,
   input  logic [7:0]    frame_prev_par,
   input  logic [aw-1:0] dstaddr_dec,
   output logic [aw-1:0] dstaddr_out,
   output logic          stream,
   output logic          hold_hdr
);

   logic       act_1;
   logic       act_2;
   logic       act_3;                           // Fresh transaction at the decode output
   align_e     al_1;
   align_e     al_2;
   logic [7:0] frame_d1;                        // Frame bits one group older
   logic [2:0] cont_lane;
   logic       cont_bit;
   logic       stream_pend;                     // Next beat is a stream beat

   // Byte after the transaction end, wraps into the next group
   assign cont_lane = 3'(al_2) + 3'd2;

   // Lanes 6 and 7 end in the second group, the others in the third
   assign cont_bit = (al_2 >= align_6) ? frame_d1[cont_lane] : frame_prev_par[cont_lane];

   always_ff @(posedge rx_lclk_div4 or posedge reset)
   begin
      if (reset)
      begin
         act_1       <= 1'b0;
         act_2       <= 1'b0;
         act_3       <= 1'b0;
         al_1        <= align_0;
         al_2        <= align_0;
         frame_d1    <= '0;
         stream_pend <= 1'b0;
         stream      <= 1'b0;
      end
      else
      begin
         act_1       <= rx_active;
         act_2       <= act_1;
         act_3       <= act_2;
         al_1        <= rx_align;
         al_2        <= al_1;
         frame_d1    <= frame_prev_par;
         stream_pend <= cont_bit & (act_2 | stream_pend);
         stream      <= stream_pend;
      end
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      if (stream_pend)
         dstaddr_out <= dstaddr_out + stream_incr;
      else
         dstaddr_out <= dstaddr_dec;
   end

   assign hold_hdr = ~act_3;                    // Header loads on a new transaction only

   a_stream_after_active : assert property (@(posedge rx_lclk_div4) disable iff (reset)
      $rose(stream) |-> $past(rx_active, 4));

endmodule

// ==== hdl/erx_packet_out.sv ====
// Output has no ready; rx_enable is asynchronous and gates access two cycles after it changes
`timescale 1ns/1ps

module erx_packet_out
   import erx_pkg::*;
(
   input  logic          reset,
   input  logic          rx_lclk_div4,
   input  logic          rx_enable,
   input  logic [3:0]    ctrlmode,
   input  datamode_e     datamode,
   input  logic          write,
   input  logic          access_dec,
   input  logic [dw-1:0] data,
   input  logic [aw-1:0] srcaddr,
   input  logic [aw-1:0] dstaddr_out,
   input  logic          stream,
   input  logic          hold_hdr,
   output logic          erx_access,
   output logic [pw-1:0] erx_packet,
   output logic          remap_bypass
);

   logic          en_meta;
   logic          en_sync;
   logic          access_q;
   logic [3:0]    ctrlmode_q;
   datamode_e     datamode_q;
   logic          write_q;
   logic [aw-1:0] dstaddr_q;
   logic [dw-1:0] data_q;
   logic [aw-1:0] srcaddr_q;

   // ####################
   // Control
   // ####################
   always_ff @(posedge rx_lclk_div4 or posedge reset)
   begin
      if (reset)
      begin
         en_meta  <= 1'b0;
         en_sync  <= 1'b0;
         access_q <= 1'b0;
      end
      else
      begin
         en_meta  <= rx_enable;
         en_sync  <= en_meta;
         access_q <= access_dec | (stream & access_q);   // Stream beats inherit access
      end
   end

   // Header from the first beat, payload every cycle
   always_ff @(posedge rx_lclk_div4)
   begin
      if (!hold_hdr)
      begin
         ctrlmode_q <= ctrlmode;
         datamode_q <= datamode;
         write_q    <= write;
      end
      dstaddr_q <= dstaddr_out;
      data_q    <= data;
      srcaddr_q <= srcaddr;
   end

   assign erx_access = access_q & en_sync;

   // ####################
   // Packing
   // ####################
   assign erx_packet[pkt_access_bit]                      = erx_access;
   assign erx_packet[pkt_write_bit]                       = write_q;
   assign erx_packet[pkt_datamode_msb:pkt_datamode_lsb]   = datamode_q;
   assign erx_packet[pkt_ctrlmode_msb:pkt_ctrlmode_lsb]   = ctrlmode_q;
   assign erx_packet[pkt_dstaddr_msb:pkt_dstaddr_lsb]     = dstaddr_q;
   assign erx_packet[pkt_data_msb:pkt_data_lsb]           = data_q;
   assign erx_packet[pkt_srcaddr_msb:pkt_srcaddr_lsb]     = srcaddr_q;

   // Writes into our own register space skip the remap
   assign remap_bypass = erx_access & write_q & (dstaddr_q[aw-1 -: 12] == rx_id);

   a_bypass_with_access : assert property (@(posedge rx_lclk_div4) disable iff (reset)
      remap_bypass |-> erx_access);

endmodule

// ==== hdl/erx_protocol_top.sv ====
// Receive path only; one packet per cycle at most and the consumer must always accept it
`timescale 1ns/1ps

module erx_protocol_top
   import erx_pkg::*;
(
   input  logic          reset,
   input  logic          rx_lclk_div4,
   input  logic          rx_enable,
   input  logic [7:0]    rx_frame_par,
   input  logic [63:0]   rx_data_par,
   output logic          erx_access,
   output logic [pw-1:0] erx_packet,
   output logic          remap_bypass
);

   // Aligner outputs
   logic [63:0]   rx_data_in;
   align_e        rx_align;
   logic          rx_active;
   logic [7:0]    frame_prev_par;

   // Decoded fields
   logic [3:0]    ctrlmode;
   logic [aw-1:0] dstaddr_dec;
   datamode_e     datamode;
   logic          write;
   logic          access_dec;
   logic [dw-1:0] data;
   logic [aw-1:0] srcaddr;

   // Stream state
   logic [aw-1:0] dstaddr_out;
   logic          stream;
   logic          hold_hdr;

   erx_frame_align i_frame_align (
      .reset          (reset),
      .rx_lclk_div4   (rx_lclk_div4),
      .rx_frame_par   (rx_frame_par),
      .rx_data_par    (rx_data_par),
      .rx_data_in     (rx_data_in),
      .rx_align       (rx_align),
      .rx_active      (rx_active),
      .frame_prev_par (frame_prev_par)
   );

   erx_field_decode i_field_decode (
      .reset        (reset),
      .rx_lclk_div4 (rx_lclk_div4),
      .rx_data_in   (rx_data_in),
      .rx_align     (rx_align),
      .rx_active    (rx_active),
      .ctrlmode     (ctrlmode),
      .dstaddr_dec  (dstaddr_dec),
      .datamode     (datamode),
      .write        (write),
      .access_dec   (access_dec),
      .data         (data),
      .srcaddr      (srcaddr)
   );

   erx_stream_track i_stream_track (
      .reset          (reset),
      .rx_lclk_div4   (rx_lclk_div4),
      .rx_align       (rx_align),
      .rx_active      (rx_active),
      .frame_prev_par (frame_prev_par),
      .dstaddr_dec    (dstaddr_dec),
      .dstaddr_out    (dstaddr_out),
      .stream         (stream),
      .hold_hdr       (hold_hdr)
   );

   erx_packet_out i_packet_out (
      .reset        (reset),
      .rx_lclk_div4 (rx_lclk_div4),
      .rx_enable    (rx_enable),
      .ctrlmode     (ctrlmode),
      .datamode     (datamode),
      .write        (write),
      .access_dec   (access_dec),
      .data         (data),
      .srcaddr      (srcaddr),
      .dstaddr_out  (dstaddr_out),
      .stream       (stream),
      .hold_hdr     (hold_hdr),
      .erx_access   (erx_access),
      .erx_packet   (erx_packet),
      .remap_bypass (remap_bypass)
   );

endmodule

// ==== verification/erx_tb_tasks.svh ====
// Included inside erx_tb only; uses its transaction variables, driver and monitor queues
`ifndef erx_tb_tasks_svh
`define erx_tb_tasks_svh

   // ####################
   // Compare tasks
   // ####################
   task automatic abort_run();
      $display("Something failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic cmp_packet(input string name, input logic [pw-1:0] exp,
                             input logic [pw-1:0] act);
      if (act !== exp)
      begin
         $display("ERR %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic cmp_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("ERR %s: expected %b, actual %b", name, exp, act);
         abort_run();
      end
   endtask

   task automatic cmp_mode(input string name, input datamode_e exp, input datamode_e act);
      if (act !== exp)
      begin
         $display("ERR %s: expected %s, actual %s", name, exp.name(), act.name());
         abort_run();
      end
   endtask

   task automatic cmp_cycle(input string name, input int exp, input int act);
      if (act != exp)
      begin
         $display("ERR %s: expected edge %0d, actual edge %0d", name, exp, act);
         abort_run();
      end
   endtask

   // ####################
   // Expected values
   // ####################

   // Layout {srcaddr, data, dstaddr, ctrlmode, datamode, write, access}
   function automatic logic [pw-1:0] exp_packet(input int beat);
      return {t_src[beat], t_data[beat], t_dst + 32'(8 * beat), t_ctrl, t_dm, t_wr, 1'b1};
   endfunction

   function automatic logic exp_bypass(input int beat);
      logic [aw-1:0] dst;
      dst = t_dst + 32'(8 * beat);
      return t_wr && (dst[31:20] == rx_id);
   endfunction

   task automatic rand_txn();
      logic [31:0] r;
      r      = rand_word();
      t_ctrl = r[3:0];
      t_dm   = datamode_e'(r[5:4]);
      t_wr   = r[6];
      t_dst  = rand_word();
      for (int b = 0; b < 4; b++)
      begin
         t_data[b] = rand_word();
         t_src[b]  = rand_word();
      end
   endtask

   // ####################
   // Directed tests
   // ####################
   task automatic check_single(input string name, input int lane);
      logic [pw-1:0] pkt;
      logic          byp;
      int            at;
      send_txn(lane, 0);
      wait_packet(name, pkt, byp, at);
      cmp_packet(name, exp_packet(0), pkt);
      cmp_bit({name, " bypass"}, exp_bypass(0), byp);
      cmp_cycle(name, g0_edge + 4, at);            // Fixed offset from the first group
      expect_quiet(name, 6);
   endtask

   task automatic reset_quiet();
      expect_quiet("reset", 12);
      @(negedge rx_lclk_div4);
      cmp_bit("reset access", 1'b0, erx_access);
      cmp_bit("reset bypass", 1'b0, remap_bypass);
   endtask

   task automatic lane_sweep();
      rand_txn();
      for (int lane = 0; lane < 8; lane++)
         check_single($sformatf("sweep lane %0d", lane), lane);
   endtask

   task automatic stream_beats(input int lane);
      logic [pw-1:0] pkt;
      logic          byp;
      int            at;
      string         name;
      name = $sformatf("stream lane %0d", lane);
      rand_txn();
      send_txn(lane, 3);
      for (int b = 0; b < 4; b++)
      begin
         wait_packet(name, pkt, byp, at);
         cmp_mode({name, " datamode"}, t_dm, datamode_e'(pkt[3:2]));   // Header kept per beat
         cmp_bit({name, " write"}, t_wr, pkt[1]);
         cmp_packet(name, exp_packet(b), pkt);
         cmp_bit({name, " bypass"}, exp_bypass(b), byp);
         cmp_cycle(name, g0_edge + 4 + b, at);     // One beat per group
      end
      expect_quiet(name, 6);
   endtask

   task automatic enable_gating();
      rand_txn();
      @(negedge rx_lclk_div4);
      rx_enable = 1'b0;
      repeat (3) @(negedge rx_lclk_div4);
      send_txn(7, 0);
      expect_quiet("enable low", 20);
      @(negedge rx_lclk_div4);
      rx_enable = 1'b1;
      repeat (2) @(posedge rx_lclk_div4);          // Through the synchronizer
      rand_txn();
      check_single("enable high", 7);
   endtask

   task automatic bypass_region();
      rand_txn();
      t_wr  = 1'b1;
      t_dst = {rx_id, t_dst[19:0]};
      check_single("remap write", 5);
      t_wr = 1'b0;
      check_single("remap read", 5);
      t_wr  = 1'b1;
      t_dst = {~rx_id, t_dst[19:0]};               // Outside the receiver region
      check_single("remap other", 5);
   endtask

`endif

// ==== verification/erx_tb.sv ====
// Groups are driven on the falling edge; packet timing is counted in rising edges of rx_lclk_div4
`timescale 1ns/1ps

module erx_tb
   import erx_pkg::*;
();

   logic          reset;
   logic          rx_lclk_div4;
   logic          rx_enable;
   logic [7:0]    rx_frame_par;
   logic [63:0]   rx_data_par;
   logic          erx_access;
   logic [pw-1:0] erx_packet;
   logic          remap_bypass;

   integer        seed = 3996;
   int            cyc = 0;                      // Rising edges so far
   int            g0_edge;                      // Edge that samples the first group

   // Current transaction with one data and srcaddr word per beat
   logic [3:0]    t_ctrl;
   logic [aw-1:0] t_dst;
   datamode_e     t_dm;
   logic          t_wr;
   logic [dw-1:0] t_data[4];
   logic [aw-1:0] t_src[4];

   logic [7:0]    byte_q[$];                    // Link bytes in time order
   logic          frame_q[$];

   // Monitor record
   logic [pw-1:0] pkt_q[$];
   logic          byp_q[$];
   int            cyc_q[$];

   erx_protocol_top i_erx_protocol_top (
      .reset        (reset),
      .rx_lclk_div4 (rx_lclk_div4),
      .rx_enable    (rx_enable),
      .rx_frame_par (rx_frame_par),
      .rx_data_par  (rx_data_par),
      .erx_access   (erx_access),
      .erx_packet   (erx_packet),
      .remap_bypass (remap_bypass)
   );

   // ####################
   // Clock and monitor
   // ####################
   initial
   begin
      rx_lclk_div4 = 1'b0;
      forever
         #50 rx_lclk_div4 = ~rx_lclk_div4;
   end

   always @(posedge rx_lclk_div4)
   begin
      cyc <= cyc + 1;
   end

   // Outputs settle after the rising edge
   always @(negedge rx_lclk_div4)
   begin
      if (erx_access === 1'b1)
      begin
         pkt_q.push_back(erx_packet);
         byp_q.push_back(remap_bypass);
         cyc_q.push_back(cyc);
      end
   end

   // ####################
   // Byte stream driver
   // ####################
   function automatic logic [31:0] rand_word();
      return $random(seed);
   endfunction

   task automatic push_byte(input logic [7:0] b, input logic f);
      byte_q.push_back(b);
      frame_q.push_back(f);
   endtask

   task automatic push_idle();
      logic [31:0] r;
      r = rand_word();
      push_byte(r[7:0], 1'b0);
   endtask

   task automatic push_word(input logic [31:0] w);    // MSB first
      for (int i = 3; i >= 0; i--)
         push_byte(w[8*i +: 8], 1'b1);
   endtask

   // Header on byte lane lane, then nbeats further beats with the frame held high
   task automatic send_txn(input int lane, input int nbeats);
      logic [31:0] r;
      int          n_grp;
      byte_q.delete();
      frame_q.delete();
      for (int i = 0; i < 7 - lane; i++)
         push_idle();
      r = rand_word();
      push_byte(r[7:0], 1'b1);                     // Header byte
      push_byte({t_ctrl, t_dst[31:28]}, 1'b1);
      push_byte(t_dst[27:20], 1'b1);
      push_byte(t_dst[19:12], 1'b1);
      push_byte(t_dst[11:4], 1'b1);
      push_byte({t_dst[3:0], t_dm, t_wr, 1'b1}, 1'b1);
      for (int b = 0; b <= nbeats; b++)
      begin
         push_word(t_data[b]);
         push_word(t_src[b]);
      end
      n_grp = (byte_q.size() + 7) / 8 + 1;         // One idle group at the end
      while (byte_q.size() < 8 * n_grp)
         push_idle();
      for (int g = 0; g < n_grp; g++)
      begin
         @(negedge rx_lclk_div4);
         if (g == 0)
            g0_edge = cyc + 1;
         for (int p = 0; p < 8; p++)
         begin
            rx_data_par[63 - 8*p -: 8] = byte_q[8*g + p];
            rx_frame_par[7 - p]        = frame_q[8*g + p];
         end
      end
   endtask

   // ####################
   // Monitor waits
   // ####################
   task automatic wait_packet(input string name, output logic [pw-1:0] pkt,
                              output logic byp, output int at);
      int n;
      n = 0;
      while (pkt_q.size() == 0)
      begin
         if (n == 20)
         begin
            $display("%s: erx_access did not arrive within 20 cycles", name);
            abort_run();
         end
         else
         begin
            @(posedge rx_lclk_div4);
            n++;
         end
      end
      pkt = pkt_q.pop_front();
      byp = byp_q.pop_front();
      at  = cyc_q.pop_front();
   endtask

   task automatic expect_quiet(input string name, input int ncyc);
      for (int i = 0; i < ncyc; i++)
      begin
         @(posedge rx_lclk_div4);
         if (pkt_q.size() != 0)
         begin
            $display("%s: unexpected erx_access at edge %0d", name, cyc_q[0]);
            abort_run();
         end
      end
   endtask

   `include "erx_tb_tasks.svh"

   initial
   begin
      reset        = 1'b1;
      rx_enable    = 1'b1;
      rx_frame_par = '0;
      rx_data_par  = '0;
      repeat (16) @(negedge rx_lclk_div4);
      reset = 1'b0;
      reset_quiet();
      rand_txn();
      check_single("single lane 7", 7);
      lane_sweep();
      stream_beats(7);
      stream_beats(2);
      enable_gating();
      bypass_region();
      $display("Everything OK");
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+verification
hdl/erx_pkg.sv
hdl/erx_frame_align.sv
hdl/erx_field_decode.sv
hdl/erx_stream_track.sv
hdl/erx_packet_out.sv
hdl/erx_protocol_top.sv
verification/erx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the receive stage and its testbench with Verilator, then run it.
# A failing check ends the simulation with $fatal, which gives a non-zero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module erx_tb -f build.f -o erx_sim

./obj_dir/erx_sim
